//--- alu.sv
`timescale 1ns/1ns

module alu
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    input  data_t   a,
    input  data_t   b,
    input  logic    carry_in,
    input  alu_op_t op,
    output data_t   result,
    output logic    n,
    output logic    v,
    output logic    z,
    output logic    c,
    input  addr_t   pc,
    output addr_t   pc_next
);

    data_t      b_eff;
    logic [8:0] sum;

    // sbc is a + ~b + c, same adder as adc
    assign b_eff = (op == alu_sub) ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {8'd0, carry_in};

    always_comb begin
        result = b;
        c      = carry_in;              // logic ops leave carry alone
        v      = 1'b0;
        case (op)
            alu_add, alu_sub: begin
                result = sum[7:0];
                c      = sum[8];        // for sub, set means no borrow
                v      = (a[7] == b_eff[7]) && (sum[7] != a[7]);
            end
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            default: result = b;        // pass_b and add_rel
        endcase
        n = result[7];
        z = (result == 8'h00);
    end

    // branch target
    assign pc_next = (op == alu_add_rel) ? pc + {{8{b[7]}}, b} : pc;

endmodule

//--- cpu_chk.sv
`timescale 1ns/1ns

module cpu_chk (
    input logic CLK,
    input logic rst,
    input logic mem_re,
    input logic mem_we,
    input logic sync
);

    // one bus direction per cycle
    read_write_excl: assert property (@(posedge CLK) !(mem_re && mem_we))
        else $error("mem_re and mem_we high in the same cycle");

    // a fetch cycle never writes
    sync_write_excl: assert property (@(posedge CLK) !(sync && mem_we))
        else $error("sync high during a write cycle");

    reset_quiet: assert property (@(posedge CLK) rst |-> !(mem_re || mem_we || sync))
        else $error("bus strobe active while rst is high");

endmodule

bind cpu_top cpu_chk chk0 (
    .CLK(CLK),
    .rst(rst),
    .mem_re(mem_re),
    .mem_we(mem_we),
    .sync(sync)
);

//--- cpu_stimulus.txt
// program bytes from 0200, data bytes at 0410, reset vector at FFFC
// records from 10000: kind (1 write, 2 fetch, 3 end of test, 0 end), addr hi, addr lo, data
@0200
A9 5A 8D 00 03 AD 10 04 8D 01 03
18 A9 70 69 25 8D 02 03 38 E9 15 8D 03 03
18 6D 11 04 8D 04 03 B0 02 A9 EE 8D 05 03
38 A9 10 E9 20 8D 06 03 B0 02 A9 33 8D 07 03
A9 F0 29 3C 8D 08 03 09 05 8D 09 03
4D 12 04 8D 0A 03 2D 13 04 0D 14 04 8D 0B 03
C9 AA F0 03 EA EA EA D0 10 90 10
C9 BB 90 02 EA EA D0 02 EA EA F0 FE
18 A9 F0 69 20 B0 02 EA EA 4C 80 02
@0280
02 A9 77 8D 0C 03 4C 86 02
@0410
C3 90 FF 0F A0
@FFFC
00 02
@10000
02 02 00 00 03 00 00 01
01 03 00 5A 01 03 01 C3 03 00 00 02
01 03 02 95 01 03 03 80 01 03 04 10 01 03 05 10 01 03 06 F0 01 03 07 33 03 00 00 03
01 03 08 30 01 03 09 35 01 03 0A CA 01 03 0B AA 03 00 00 04
02 02 51 00 02 02 53 00 02 02 58 00 02 02 5A 00 02 02 5C 00 02 02 5E 00 02 02 62 00
02 02 66 00 02 02 68 00 02 02 69 00 02 02 6B 00 02 02 6D 00 02 02 71 00 03 00 00 05
02 02 80 00 02 02 81 00 01 03 0C 77 03 00 00 06 00 00 00 00

//--- cpu_top.sv
`timescale 1ns/1ns

module cpu_top
    import cpu_types_pkg::*;
    import isa_pkg::*;
#(
    parameter addr_t reset_vec_addr = default_reset_vec
) (
    input  logic  CLK,
    input  logic  rst,
    input  data_t mem_rdata,
    output addr_t mem_addr,
    output data_t mem_wdata,
    output logic  mem_re,
    output logic  mem_we,
    output logic  sync
);

    addr_mode_t mode;
    exec_op_t   op;
    logic       illegal;
    flags_t     flags, alu_flags;
    addr_sel_t  addr_sel;
    alu_op_t    alu_op;
    logic       ld_mar, ld_mdr_lo, ld_mdr_hi, ld_a, ld_flags, ld_pc;
    logic       pc_inc, dec_load, alu_src_a, carry_set, carry_clr;
    data_t      a_reg, mdr_lo, alu_result;
    addr_t      pc, alu_pc;

    ctrl_fsm u_ctrl (
        .CLK(CLK), .rst(rst), .mode(mode), .op(op), .illegal(illegal), .flags(flags),
        .addr_sel(addr_sel), .mem_re(mem_re), .mem_we(mem_we), .sync(sync),
        .ld_mar(ld_mar), .ld_mdr_lo(ld_mdr_lo), .ld_mdr_hi(ld_mdr_hi), .ld_a(ld_a),
        .ld_flags(ld_flags), .ld_pc(ld_pc), .pc_inc(pc_inc), .dec_load(dec_load),
        .alu_op(alu_op), .alu_src_a(alu_src_a),
        .carry_set(carry_set), .carry_clr(carry_clr)
    );

    // opcode sits in mdr_lo after fetch
    opcode_decode u_dec (
        .CLK(CLK), .rst(rst), .load(dec_load), .opcode(mdr_lo),
        .mode(mode), .op(op), .illegal(illegal)
    );

    datapath #(.reset_vec_addr(reset_vec_addr)) u_dp (
        .CLK(CLK), .rst(rst), .addr_sel(addr_sel), .ld_mar(ld_mar),
        .ld_mdr_lo(ld_mdr_lo), .ld_mdr_hi(ld_mdr_hi), .ld_a(ld_a), .ld_flags(ld_flags),
        .ld_pc(ld_pc), .pc_inc(pc_inc), .alu_op(alu_op), .alu_src_a(alu_src_a),
        .carry_set(carry_set), .carry_clr(carry_clr), .alu_result(alu_result),
        .alu_flags(alu_flags), .alu_pc(alu_pc), .mem_rdata(mem_rdata),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .a_reg(a_reg), .mdr_lo(mdr_lo),
        .pc(pc), .flags(flags)
    );

    alu u_alu (
        .a(a_reg), .b(mdr_lo), .carry_in(flags[flag_c]), .op(alu_op),
        .result(alu_result), .n(alu_flags[flag_n]), .v(alu_flags[flag_v]),
        .z(alu_flags[flag_z]), .c(alu_flags[flag_c]), .pc(pc), .pc_next(alu_pc)
    );

endmodule

//--- cpu_types_pkg.sv
package cpu_types_pkg;

    typedef logic [7:0]  data_t;    // one data byte
    typedef logic [15:0] addr_t;    // memory address

    // status flags, packed as n v z c
    typedef logic [3:0]  flags_t;

    // bit positions inside flags_t
    localparam int flag_n = 3;
    localparam int flag_v = 2;
    localparam int flag_z = 1;
    localparam int flag_c = 0;

    // low byte of the reset vector, high byte sits right above it
    localparam addr_t default_reset_vec = 16'hFFFC;

endpackage

//--- ctrl_fsm.sv
`timescale 1ns/1ns

module ctrl_fsm
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  addr_mode_t mode,
    input  exec_op_t   op,
    input  logic       illegal,
    input  flags_t     flags,
    output addr_sel_t  addr_sel,
    output logic       mem_re,
    output logic       mem_we,
    output logic       sync,
    output logic       ld_mar,
    output logic       ld_mdr_lo,
    output logic       ld_mdr_hi,
    output logic       ld_a,
    output logic       ld_flags,
    output logic       ld_pc,
    output logic       pc_inc,
    output logic       dec_load,
    output alu_op_t    alu_op,
    output logic       alu_src_a,    // pc takes the branch adder, not mdr
    output logic       carry_set,
    output logic       carry_clr
);

    ctrl_state_t state_q, state_d;
    logic        re, we, sy;         // strobes before reset masking
    logic        reads_data;
    logic        take;

    always_ff @(posedge CLK) begin
        if (rst)
            state_q <= reset_0;
        else
            state_q <= state_d;
    end

    always_comb begin
        reads_data = !(op inside {sta, jmp});
        case (op)
            beq:     take = flags[flag_z];
            bne:     take = !flags[flag_z];
            bcc:     take = !flags[flag_c];
            bcs:     take = flags[flag_c];
            default: take = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // next state and control outputs
    always_comb begin
        state_d   = fetch;
        addr_sel  = sel_pc;
        re        = 1'b0;
        we        = 1'b0;
        sy        = 1'b0;
        ld_mar    = 1'b0;
        ld_mdr_lo = 1'b0;
        ld_mdr_hi = 1'b0;
        ld_a      = 1'b0;
        ld_flags  = 1'b0;
        ld_pc     = 1'b0;
        pc_inc    = 1'b0;
        dec_load  = 1'b0;
        alu_op    = alu_pass_b;
        alu_src_a = 1'b0;
        carry_set = 1'b0;
        carry_clr = 1'b0;

        case (state_q)
            reset_0: begin                  // vector low byte
                addr_sel  = sel_vector;
                re        = 1'b1;
                ld_mdr_lo = 1'b1;
                state_d   = reset_1;
            end
            reset_1: begin                  // vector high byte
                addr_sel  = sel_vector;
                re        = 1'b1;
                ld_mdr_hi = 1'b1;
                state_d   = reset_2;
            end
            reset_2: begin
                ld_pc = 1'b1;               // pc <= mdr
            end
            fetch: begin
                re        = 1'b1;
                sy        = 1'b1;
                ld_mdr_lo = 1'b1;
                pc_inc    = 1'b1;
                state_d   = decode;
            end
            decode: begin
                dec_load = 1'b1;
                if (illegal)
                    state_d = addr_none;
                else begin
                    case (mode)
                        immed:   state_d = addr_immed;
                        abs:     state_d = addr_abs;
                        rel:     state_d = addr_rel;
                        default: state_d = exec;
                    endcase
                end
            end
            addr_none: state_d = fetch;     // undefined opcode, skip it
            addr_immed, addr_rel: begin
                re        = 1'b1;
                ld_mdr_lo = 1'b1;
                pc_inc    = 1'b1;
                // cmp has no borrow in, preset c before the subtract
                carry_set = (op == cmp);
                state_d   = exec;
            end
            addr_abs: begin
                re        = 1'b1;
                ld_mdr_lo = 1'b1;
                ld_mar    = 1'b1;           // mar holds operand address
                pc_inc    = 1'b1;
                state_d   = addr_abs1;
            end
            addr_abs1: begin
                addr_sel  = sel_mar_plus1;
                re        = 1'b1;
                ld_mdr_hi = 1'b1;
                pc_inc    = 1'b1;
                state_d   = addr_abs2;
            end
            addr_abs2: begin
                addr_sel = sel_mdr;
                if (op == jmp) begin
                    ld_pc   = 1'b1;
                    state_d = fetch;
                end else begin
                    ld_mar    = 1'b1;
                    re        = reads_data;
                    ld_mdr_lo = reads_data;
                    carry_set = (op == cmp);
                    state_d   = exec;
                end
            end
            exec: begin
                case (op)
                    lda: begin
                        ld_a     = 1'b1;
                        ld_flags = 1'b1;
                    end
                    sta: begin
                        addr_sel = sel_mar;
                        we       = 1'b1;
                    end
                    adc, sbc, and_op, ora, eor: begin
                        case (op)
                            adc:     alu_op = alu_add;
                            sbc:     alu_op = alu_sub;
                            and_op:  alu_op = alu_and;
                            ora:     alu_op = alu_or;
                            default: alu_op = alu_xor;
                        endcase
                        ld_a     = 1'b1;
                        ld_flags = 1'b1;
                    end
                    cmp: begin
                        alu_op   = alu_sub;
                        ld_flags = 1'b1;    // result dropped
                    end
                    clc: carry_clr = 1'b1;
                    sec: carry_set = 1'b1;
                    beq, bne, bcc, bcs: state_d = take ? branch_take : fetch;
                    default: state_d = fetch;
                endcase
            end
            branch_take: begin              // pc + signed offset
                alu_op    = alu_add_rel;
                alu_src_a = 1'b1;
                ld_pc     = 1'b1;
            end
            default: state_d = fetch;
        endcase
    end

    // bus strobes stay quiet while reset is held
    assign mem_re = re & ~rst;
    assign mem_we = we & ~rst;
    assign sync   = sy & ~rst;

endmodule

//--- datapath.sv
`timescale 1ns/1ns

module datapath
    import cpu_types_pkg::*;
    import isa_pkg::*;
#(
    parameter addr_t reset_vec_addr = default_reset_vec
) (
    input  logic      CLK,
    input  logic      rst,
    input  addr_sel_t addr_sel,
    input  logic      ld_mar,
    input  logic      ld_mdr_lo,
    input  logic      ld_mdr_hi,
    input  logic      ld_a,
    input  logic      ld_flags,
    input  logic      ld_pc,
    input  logic      pc_inc,
    input  alu_op_t   alu_op,
    input  logic      alu_src_a,
    input  logic      carry_set,
    input  logic      carry_clr,
    input  data_t     alu_result,
    input  flags_t    alu_flags,
    input  addr_t     alu_pc,
    input  data_t     mem_rdata,
    output addr_t     mem_addr,
    output data_t     mem_wdata,
    output data_t     a_reg,
    output data_t     mdr_lo,
    output addr_t     pc,
    output flags_t    flags
);

    addr_t  pc_q, mar_q;
    data_t  a_q, mdr_lo_q, mdr_hi_q;
    flags_t flags_q;
    addr_t  mdr_addr;
    logic   v_upd;

    assign mdr_addr = {mdr_hi_q, mdr_lo_q};
    // only adc and sbc touch v, cmp shares the subtract but loads no a
    assign v_upd = ld_a && (alu_op == alu_add || alu_op == alu_sub);

    //////////////////////////////////////////////////////////////////////
    // control registers
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc_q    <= '0;
            a_q     <= '0;
            flags_q <= '0;
        end else begin
            if (ld_pc)
                pc_q <= alu_src_a ? alu_pc : mdr_addr;
            else if (pc_inc)
                pc_q <= pc_q + 16'd1;
            if (ld_a)
                a_q <= alu_result;
            if (ld_flags) begin
                flags_q[flag_n] <= alu_flags[flag_n];
                flags_q[flag_z] <= alu_flags[flag_z];
                flags_q[flag_c] <= alu_flags[flag_c];
                if (v_upd)
                    flags_q[flag_v] <= alu_flags[flag_v];
            end else if (carry_set)
                flags_q[flag_c] <= 1'b1;
            else if (carry_clr)
                flags_q[flag_c] <= 1'b0;
        end
    end

    // mar and mdr
    always_ff @(posedge CLK) begin
        if (ld_mar)
            mar_q <= mem_addr;
        if (ld_mdr_lo)
            mdr_lo_q <= mem_rdata;
        if (ld_mdr_hi)
            mdr_hi_q <= mem_rdata;
    end

    always_comb begin
        case (addr_sel)
            sel_mar:       mem_addr = mar_q;
            sel_mar_plus1: mem_addr = mar_q + 16'd1;
            sel_mdr:       mem_addr = mdr_addr;
            // high byte is read in the cycle that loads mdr_hi
            sel_vector:    mem_addr = reset_vec_addr + {15'd0, ld_mdr_hi};
            default:       mem_addr = pc_q;
        endcase
    end

    assign mem_wdata = a_q;             // sta stores a
    assign a_reg     = a_q;
    assign mdr_lo    = mdr_lo_q;
    assign pc        = pc_q;
    assign flags     = flags_q;

endmodule

//--- filelist.f
cpu_types_pkg.sv
isa_pkg.sv
opcode_decode.sv
ctrl_fsm.sv
alu.sv
datapath.sv
cpu_top.sv
cpu_chk.sv
tb_clock.sv
tb_top.sv

//--- isa_pkg.sv
package isa_pkg;
    import cpu_types_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // opcodes, standard 6502 encodings
    localparam data_t op_lda_imm = 8'hA9;
    localparam data_t op_lda_abs = 8'hAD;
    localparam data_t op_sta_abs = 8'h8D;
    localparam data_t op_adc_imm = 8'h69;
    localparam data_t op_adc_abs = 8'h6D;
    localparam data_t op_sbc_imm = 8'hE9;
    localparam data_t op_sbc_abs = 8'hED;
    localparam data_t op_and_imm = 8'h29;
    localparam data_t op_and_abs = 8'h2D;
    localparam data_t op_ora_imm = 8'h09;
    localparam data_t op_ora_abs = 8'h0D;
    localparam data_t op_eor_imm = 8'h49;
    localparam data_t op_eor_abs = 8'h4D;
    localparam data_t op_cmp_imm = 8'hC9;
    localparam data_t op_cmp_abs = 8'hCD;
    localparam data_t op_clc     = 8'h18;
    localparam data_t op_sec     = 8'h38;
    localparam data_t op_jmp_abs = 8'h4C;
    localparam data_t op_beq     = 8'hF0;
    localparam data_t op_bne     = 8'hD0;
    localparam data_t op_bcc     = 8'h90;
    localparam data_t op_bcs     = 8'hB0;
    localparam data_t op_nop     = 8'hEA;

    //////////////////////////////////////////////////////////////////////
    // control sequencer states
    typedef enum logic [3:0] {
        reset_0, reset_1, reset_2,
        fetch, decode,
        addr_abs, addr_abs1, addr_abs2,
        addr_immed, addr_rel, addr_none,
        exec, branch_take
    } ctrl_state_t;

    typedef enum logic [1:0] {none, immed, abs, rel} addr_mode_t;

    // what exec does, one per mnemonic
    typedef enum logic [3:0] {
        lda, sta, adc, sbc, and_op, ora, eor, cmp,
        clc, sec, jmp, beq, bne, bcc, bcs, nop
    } exec_op_t;

    typedef enum logic [2:0] {
        alu_pass_b, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_add_rel
    } alu_op_t;

    // memory address source
    typedef enum logic [2:0] {
        sel_pc, sel_mar, sel_mar_plus1, sel_mdr, sel_vector
    } addr_sel_t;

endpackage

//--- opcode_decode.sv
`timescale 1ns/1ns

module opcode_decode
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       load,       // high in the decode cycle
    input  data_t      opcode,     // opcode byte held in mdr
    output addr_mode_t mode,
    output exec_op_t   op,
    output logic       illegal
);

    addr_mode_t mode_d, mode_q;
    exec_op_t   op_d, op_q;
    logic       illegal_d, illegal_q;

    // address mode
    always_comb begin
        case (opcode)
            op_lda_imm, op_adc_imm, op_sbc_imm, op_and_imm,
            op_ora_imm, op_eor_imm, op_cmp_imm:              mode_d = immed;
            op_lda_abs, op_sta_abs, op_adc_abs, op_sbc_abs, op_and_abs,
            op_ora_abs, op_eor_abs, op_cmp_abs, op_jmp_abs:  mode_d = abs;
            op_beq, op_bne, op_bcc, op_bcs:                  mode_d = rel;
            default:                                         mode_d = none;
        endcase
    end

    // execute operation, unknown bytes fall out as nop
    always_comb begin
        illegal_d = 1'b0;
        case (opcode)
            op_lda_imm, op_lda_abs: op_d = lda;
            op_sta_abs:             op_d = sta;
            op_adc_imm, op_adc_abs: op_d = adc;
            op_sbc_imm, op_sbc_abs: op_d = sbc;
            op_and_imm, op_and_abs: op_d = and_op;
            op_ora_imm, op_ora_abs: op_d = ora;
            op_eor_imm, op_eor_abs: op_d = eor;
            op_cmp_imm, op_cmp_abs: op_d = cmp;
            op_clc:                 op_d = clc;
            op_sec:                 op_d = sec;
            op_jmp_abs:             op_d = jmp;
            op_beq:                 op_d = beq;
            op_bne:                 op_d = bne;
            op_bcc:                 op_d = bcc;
            op_bcs:                 op_d = bcs;
            op_nop:                 op_d = nop;
            default: begin
                op_d      = nop;
                illegal_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            mode_q    <= none;
            op_q      <= nop;
            illegal_q <= 1'b0;
        end else if (load) begin
            mode_q    <= mode_d;
            op_q      <= op_d;
            illegal_q <= illegal_d;
        end
    end

    // decode result is visible already in the load cycle, so the
    // sequencer can pick the address state right out of decode
    assign mode    = load ? mode_d : mode_q;
    assign op      = load ? op_d : op_q;
    assign illegal = load ? illegal_d : illegal_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f filelist.f \
    --Mdir obj_dir -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic CLK,
    output logic rst
);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;      // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge CLK);
        #1 rst = 1'b0;              // released just after the edge
    end

endmodule

//--- tb_top.sv
`timescale 1ns/1ns

module tb_top
    import cpu_types_pkg::*;
();

    localparam int timeout_cycles = 64;

    logic  CLK, rst;
    data_t mem_rdata, mem_wdata;
    addr_t mem_addr;
    logic  mem_re, mem_we, sync;

    // 64 KiB memory image with expected records from 10000 on
    logic [7:0]  image [0:'h100FF];
    logic [16:0] rp;                // record pointer
    logic [7:0]  kind;
    addr_t       exp_addr;
    data_t       exp_data;

    logic  pend_we;
    addr_t pend_addr;
    data_t pend_data;

    int   errors, test_errs, tests_passed, tests_failed, cyc, n;
    logic found, timed_out;

    tb_clock clk0 (.CLK(CLK), .rst(rst));

    cpu_top #(.reset_vec_addr(default_reset_vec)) dut0 (
        .CLK(CLK), .rst(rst), .mem_rdata(mem_rdata), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_re(mem_re), .mem_we(mem_we), .sync(sync)
    );

    //////////////////////////////////////////////////////////////////////
    // memory model
    assign mem_rdata = image[{1'b0, mem_addr}];   // combinational read

    always @(negedge CLK) begin
        pend_we   <= mem_we;
        pend_addr <= mem_addr;
        pend_data <= mem_wdata;
    end

    always @(posedge CLK) begin
        #1;
        if (pend_we)
            image[{1'b0, pend_addr}] = pend_data;
    end

    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic load_record;
        kind     = image[rp];
        exp_addr = {image[rp + 17'd1], image[rp + 17'd2]};
        exp_data = image[rp + 17'd3];
        rp       = rp + 17'd4;
    endtask

    // sampled at the falling edge where strobes have settled
    task automatic wait_bus(input logic want_write, output logic hit);
        int k;
        hit = 1'b0;
        for (k = 0; k < timeout_cycles && !hit; k++) begin
            @(negedge CLK);
            if (want_write ? mem_we : sync)
                hit = 1'b1;
        end
    endtask

    task automatic close_test(input data_t num);
        if (test_errs == 0) begin
            $display("test %0d passed", num);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", num, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin
        for (int i = 0; i < 'h10100; i++)
            image[i[16:0]] = i[7:0] ^ i[15:8] ^ {7'd0, i[16]};
        $readmemh("cpu_stimulus.txt", image);
        rp           = 17'h10000;
        errors       = 0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        // first record is the fetch at the reset vector target
        load_record;
        cyc   = 0;
        found = 1'b0;
        for (n = 0; n < timeout_cycles && !found; n++) begin
            @(negedge CLK);
            if (!rst) begin
                if (sync)
                    found = 1'b1;
                else
                    cyc++;
            end
        end
        if (!found) begin
            $display("timeout: first instruction fetch after reset never arrived");
            timed_out = 1'b1;
        end else begin
            check_value("sync mem_addr", mem_addr, exp_addr);
            check_value("mem_re", {15'd0, mem_re}, 16'd1);
            check_value("reset to sync cycles", cyc[15:0], 16'd3);
        end

        while (!timed_out && kind != 8'h00) begin
            load_record;
            case (kind)
                8'h01: begin
                    wait_bus(1'b1, found);
                    if (!found) begin
                        $display("timeout: expected bus write never arrived");
                        timed_out = 1'b1;
                    end else begin
                        check_value("mem_addr", mem_addr, exp_addr);
                        check_value("mem_wdata", {8'h00, mem_wdata}, {8'h00, exp_data});
                    end
                end
                8'h02: begin
                    wait_bus(1'b0, found);
                    if (!found) begin
                        $display("timeout: expected instruction fetch never arrived");
                        timed_out = 1'b1;
                    end else begin
                        check_value("sync mem_addr", mem_addr, exp_addr);
                        check_value("mem_re", {15'd0, mem_re}, 16'd1);
                    end
                end
                8'h03: close_test(exp_data);
                8'h00: ;                        // end of list
                default: begin
                    $display("stimulus file holds an unknown record kind %h", kind);
                    errors++;
                    kind = 8'h00;
                end
            endcase
        end

        $display("passed %0d failed %0d", tests_passed, tests_failed);
        if (!timed_out && errors == 0 && tests_failed == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
